// ==== sources.f ====
+incdir+hdl
hdl/analyzer_cfg_pkg.sv
hdl/analyzer_result_pkg.sv
hdl/point_window_sampler.sv
hdl/line_scanner.sv
hdl/blink_period_classifier.sv
hdl/result_reporter.sv
hdl/frequency_analyzer_top.sv
testbench/tb_clock_gen.sv
testbench/analyzer_checker.sv
testbench/tb_frequency_analyzer.sv

// ==== Makefile ====
VERILATOR    ?= verilator
TOP          := tb_frequency_analyzer
RTL_TOP      := frequency_analyzer_top
FILELIST     := sources.f
BUILD_DIR    := obj_dir
LOG          := sim.log
COMMON_FLAGS := --timing --timescale 1ns/100ps -f $(FILELIST)
LINT_FLAGS   := --lint-only -Wall
SIM_FLAGS    := --binary -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_frequency_analyzer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "analyzer_macros.svh"

module tb_frequency_analyzer;

    import analyzer_cfg_pkg::*;
    import analyzer_result_pkg::*;

    localparam real CLOCK_PERIOD = 4.0;
    localparam int  MAX_LINES    = 128;
    localparam int  FIRST_RUN    = 60;
    localparam int  SECOND_RUN   = 40;
    localparam int  TOTAL_LINES  = FIRST_RUN + SECOND_RUN;
    localparam int  WINDOW_WIDTH = 40;
    localparam int  IRQ_TIMEOUT  = 32;

    localparam logic [`PIXEL_WIDTH-1:0] THRESHOLD   = 8'd100;
    localparam logic [`PIXEL_WIDTH-1:0] DARK_VALUE  = 8'd20;
    localparam logic [`PIXEL_WIDTH-1:0] LIT_VALUE   = 8'd200;
    localparam logic [`PIXEL_WIDTH-1:0] SPIKE_VALUE = 8'd255;

    logic                    pixel_clock;
    logic                    rst;
    logic [`PIXEL_WIDTH-1:0] data;
    logic                    start;
    logic                    stop;
    logic                    clear;
    analyzer_cfg_t           cfg;
    logic                    report_valid;
    report_word_t            report;
    logic                    irq;

    logic [`POINT_COUNT-1:0][MAX_LINES-1:0] planned_bits;
    int     line_total;
    int     clear_mark;
    int     stop_count;
    int     irq_timeouts;
    int     check_count;
    int     value_errors;
    int     event_errors;
    int     report_count;
    integer seed;
    int     blink_line;
    int     segment_index;
    int     segment_pos;

    tb_clock_gen
    #(
        .CLOCK_PERIOD (CLOCK_PERIOD),
        .RESET_CYCLES (8)
    )
    u_clock
    (
        .pixel_clock (pixel_clock),
        .rst         (rst)
    );

    frequency_analyzer_top u_dut
    (
        .pixel_clock  (pixel_clock),
        .rst          (rst),
        .data         (data),
        .start        (start),
        .stop         (stop),
        .clear        (clear),
        .cfg          (cfg),
        .report_valid (report_valid),
        .report       (report),
        .irq          (irq)
    );

    analyzer_checker
    #(
        .MAX_LINES (MAX_LINES)
    )
    u_checker
    (
        .pixel_clock  (pixel_clock),
        .rst          (rst),
        .stop         (stop),
        .cfg          (cfg),
        .report_valid (report_valid),
        .report       (report),
        .irq          (irq),
        .planned_bits (planned_bits),
        .line_total   (line_total),
        .clear_mark   (clear_mark),
        .check_count  (check_count),
        .value_errors (value_errors),
        .event_errors (event_errors),
        .report_count (report_count)
    );

    function automatic int window_start(input int point);
        return 100 + 300 * point;
    endfunction

    // point 2 periods stay outside both of its bands
    function automatic int segment_length(input int index);
        case (index % 4)
            0:       return 3;
            1:       return 14;
            2:       return 20;
            default: return 8;
        endcase
    endfunction

    function automatic logic [`PIXEL_WIDTH-1:0] window_pixel
    (
        input logic lit,
        input int   offset,
        input int   line
    );
        if (lit)
        begin
            // single bright pixel still reads as light
            if ((line % 4) == 1)
                return (offset == 7) ? SPIKE_VALUE : DARK_VALUE;
            return LIT_VALUE;
        end
        // flat at the threshold reads as dark
        if ((line % 3) == 0)
            return THRESHOLD;
        return DARK_VALUE;
    endfunction

    task automatic next_cycle();
        @(posedge pixel_clock);
        #1;
    endtask

    task automatic configure();
        int p;
        cfg           = '0;
        cfg.threshold = THRESHOLD;
        for (p = 0; p < `POINT_COUNT; p++)
        begin
            cfg.windows[p].start_index = `LINE_INDEX_WIDTH'(window_start(p));
            cfg.windows[p].stop_index  = `LINE_INDEX_WIDTH'(window_start(p) + WINDOW_WIDTH);
        end
        // point 0 in f0, point 1 in f1, point 2 in neither
        cfg.bands[0].f0_period = 16'd6;
        cfg.bands[0].f1_period = 16'd10;
        cfg.bands[0].deviation = 16'd1;
        cfg.bands[1].f0_period = 16'd16;
        cfg.bands[1].f1_period = 16'd10;
        cfg.bands[1].deviation = 16'd2;
        cfg.bands[2].f0_period = 16'd12;
        cfg.bands[2].f1_period = 16'd17;
        cfg.bands[2].deviation = 16'd1;
    endtask

    task automatic plan_line(output logic [`POINT_COUNT-1:0] bits);
        int p;
        bits[0] = ((blink_line % 6) < 3);
        bits[1] = ((blink_line % 10) < 5);
        bits[2] = (segment_pos < (segment_length(segment_index) + 1) / 2);
        segment_pos++;
        if (segment_pos == segment_length(segment_index))
        begin
            segment_pos = 0;
            segment_index++;
        end
        blink_line++;
        for (p = 0; p < `POINT_COUNT; p++)
            planned_bits[p][line_total] = bits[p];
        line_total++;
    endtask

    task automatic drive_line(input logic [`POINT_COUNT-1:0] bits, input int line);
        int   pos;
        int   p;
        int   owner;
        logic noisy;
        noisy = ((line % 7) == 3);
        for (pos = 0; pos < `LINE_PIXELS; pos++)
        begin
            owner = -1;
            for (p = 0; p < `POINT_COUNT; p++)
                if ((pos >= window_start(p)) && (pos < window_start(p) + WINDOW_WIDTH))
                    owner = p;
            if (owner >= 0)
                data = window_pixel(bits[owner], pos - window_start(owner), line);
            else if (noisy)
                data = `PIXEL_WIDTH'($random(seed));
            else
                data = DARK_VALUE;
            next_cycle();
        end
    endtask

    task automatic run_lines(input int count);
        logic [`POINT_COUNT-1:0] bits;
        int                      n;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        for (n = 0; n < count; n++)
        begin
            plan_line(bits);
            drive_line(bits, line_total - 1);
        end
    endtask

    task automatic request_report(input logic extra_stop);
        int cycles;
        stop = 1'b1;
        next_cycle();
        stop = 1'b0;
        stop_count++;
        if (extra_stop)
        begin
            // lands mid-report
            repeat (3)
                next_cycle();
            stop = 1'b1;
            next_cycle();
            stop = 1'b0;
        end
        cycles = 0;
        while ((irq !== 1'b1) && (cycles < IRQ_TIMEOUT))
        begin
            next_cycle();
            cycles++;
        end
        if (irq !== 1'b1)
        begin
            $display("no irq within %0d cycles of the stop pulse", IRQ_TIMEOUT);
            irq_timeouts++;
        end
        repeat (4)
            next_cycle();
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial
    begin
        seed          = 32'h0b98f673;
        data          = DARK_VALUE;
        start         = 1'b0;
        stop          = 1'b0;
        clear         = 1'b0;
        planned_bits  = '0;
        line_total    = 0;
        clear_mark    = 0;
        stop_count    = 0;
        irq_timeouts  = 0;
        blink_line    = 0;
        segment_index = 0;
        segment_pos   = 0;
        configure();
        while (rst !== 1'b0)
            next_cycle();

        // idle period with nothing to report
        repeat (20)
            next_cycle();

        run_lines(FIRST_RUN);
        request_report(1'b0);

        // cleared counts report as zeros
        clear_mark = line_total;
        clear      = 1'b1;
        next_cycle();
        clear = 1'b0;
        request_report(1'b0);

        run_lines(SECOND_RUN);
        request_report(1'b1);

        $display("checks %0d, value errors %0d, event errors %0d, timeouts %0d, reports %0d/%0d",
                 check_count, value_errors, event_errors, irq_timeouts, report_count, stop_count);
        if ((value_errors == 0) && (event_errors == 0) && (irq_timeouts == 0)
            && (report_count == stop_count))
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin : watchdog
        realtime limit;
        limit = TOTAL_LINES * `LINE_PIXELS * CLOCK_PERIOD * 1.5 + 1000.0;
        #(limit);
        $display("watchdog expired at %0t, the run did not finish", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/analyzer_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "analyzer_macros.svh"

module analyzer_checker
#(
    parameter int MAX_LINES = 128
)
(
    input  logic                                   pixel_clock,
    input  logic                                   rst,
    input  logic                                   stop,
    input  analyzer_cfg_pkg::analyzer_cfg_t        cfg,
    input  logic                                   report_valid,
    input  analyzer_result_pkg::report_word_t      report,
    input  logic                                   irq,
    input  logic [`POINT_COUNT-1:0][MAX_LINES-1:0] planned_bits,
    input  int                                     line_total,
    input  int                                     clear_mark,
    output int                                     check_count,
    output int                                     value_errors,
    output int                                     event_errors,
    output int                                     report_count
);

    import analyzer_result_pkg::*;

    typedef logic [`RESULT_COUNT-1:0][`COUNT_WIDTH-1:0] word_list_t;

    localparam int IRQ_STEP = `RESULT_COUNT + 1;

    word_list_t expected_words;
    int         step;
    logic       accept_stop;

    function automatic logic band_hit(input int period, input int center, input int deviation);
        return (period >= center - deviation) && (period <= center + deviation);
    endfunction

    // expected counts of one point from its planned bits
    function automatic point_counts_t reference_counts(input int point);
        point_counts_t counts;
        logic          previous;
        logic          current;
        logic          armed;
        int            last_edge;
        int            period;
        int            line;
        counts    = '0;
        previous  = 1'b0;
        armed     = 1'b0;
        last_edge = 0;
        for (line = 0; line <= line_total; line++)
        begin
            // clear keeps the previous bit
            if (line == clear_mark)
            begin
                counts = '0;
                armed  = 1'b0;
            end
            if (line < line_total)
            begin
                current = planned_bits[point][line];
                if (current && !previous)
                begin
                    if (armed)
                    begin
                        period = line - last_edge;
                        if (band_hit(period, int'(cfg.bands[point].f0_period),
                                     int'(cfg.bands[point].deviation)))
                            counts.f0_count = counts.f0_count + 1;
                        else if (band_hit(period, int'(cfg.bands[point].f1_period),
                                          int'(cfg.bands[point].deviation)))
                            counts.f1_count = counts.f1_count + 1;
                        else
                            counts.unknown_count = counts.unknown_count + 1;
                    end
                    armed     = 1'b1;
                    last_edge = line;
                end
                previous = current;
            end
        end
        return counts;
    endfunction

    // register order, f0/f1 per point then the unknowns
    function automatic word_list_t reference_report();
        point_counts_t counts [`POINT_COUNT];
        word_list_t    words;
        int            p;
        for (p = 0; p < `POINT_COUNT; p++)
            counts[p] = reference_counts(p);
        for (p = 0; p < `POINT_COUNT; p++)
        begin
            words[2 * p]     = counts[p].f0_count;
            words[2 * p + 1] = counts[p].f1_count;
            words[2 * `POINT_COUNT + p] = counts[p].unknown_count;
        end
        return words;
    endfunction

    task automatic check_word();
        logic [`REPORT_INDEX_WIDTH-1:0] want_index;
        logic [`COUNT_WIDTH-1:0]        want_data;
        want_index = `REPORT_INDEX_WIDTH'(step);
        want_data  = expected_words[step - 1];
        if (irq !== 1'b0)
        begin
            $display("irq raised before the last report word, at word %0d", step);
            event_errors++;
        end
        if (report_valid !== 1'b1)
        begin
            $display("report word %0d missing, report_valid low at %0t", step, $time);
            event_errors++;
        end
        else
        begin
            check_count += 2;
            if (report.index !== want_index)
            begin
                $display("[ERROR] report.index expected %h got %h", want_index, report.index);
                value_errors++;
            end
            if (report.data !== want_data)
            begin
                $display("[ERROR] report.data word %0d expected %h got %h",
                         step, want_data, report.data);
                value_errors++;
            end
        end
    endtask

    task automatic check_irq();
        check_count++;
        if (irq !== 1'b1)
        begin
            $display("irq missing one cycle after report word %0d", `RESULT_COUNT);
            event_errors++;
        end
        else
            report_count++;
        if (report_valid !== 1'b0)
        begin
            $display("report_valid still high after the last report word");
            event_errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // report tracking, sampled at the clock edge
    //////////////////////////////////////////////////

    always @(posedge pixel_clock)
    begin
        if (rst)
            step = 0;
        else
        begin
            if ((step >= 1) && (step <= `RESULT_COUNT))
                check_word();
            else if (step == IRQ_STEP)
                check_irq();
            else if ((report_valid !== 1'b0) || (irq !== 1'b0))
            begin
                $display("report_valid or irq active at %0t with no stop pulse", $time);
                event_errors++;
            end

            // a stop in the middle of a report is dropped
            accept_stop = stop && ((step == 0) || (step == IRQ_STEP));
            if (step == IRQ_STEP)
                step = 0;
            else if (step != 0)
                step++;
            if (accept_stop)
            begin
                expected_words = reference_report();
                step           = 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
#(
    parameter real CLOCK_PERIOD = 4.0,
    parameter int  RESET_CYCLES = 8
)
(
    output logic pixel_clock,
    output logic rst
);

    initial
    begin
        pixel_clock = 1'b0;
        forever
            #(CLOCK_PERIOD / 2.0) pixel_clock = ~pixel_clock;
    end

    // release just after an edge, like the other inputs
    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES)
            @(posedge pixel_clock);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== hdl/frequency_analyzer_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "analyzer_macros.svh"

module frequency_analyzer_top
(
    input  logic                              pixel_clock,
    input  logic                              rst,
    input  logic [`PIXEL_WIDTH-1:0]           data,
    input  logic                              start,
    input  logic                              stop,
    input  logic                              clear,
    input  analyzer_cfg_pkg::analyzer_cfg_t   cfg,
    output logic                              report_valid,
    output analyzer_result_pkg::report_word_t report,
    output logic                              irq
);

    import analyzer_result_pkg::*;

    logic [`POINT_COUNT-1:0]          sample_bits;
    logic [`POINT_COUNT-1:0]          sample_valid;
    point_counts_t [`POINT_COUNT-1:0] point_counts;

    line_scanner u_scanner
    (
        .pixel_clock  (pixel_clock),
        .rst          (rst),
        .start        (start),
        .stop         (stop),
        .data         (data),
        .threshold    (cfg.threshold),
        .windows      (cfg.windows),
        .sample_bits  (sample_bits),
        .sample_valid (sample_valid)
    );

    // one classifier per point
    for (genvar i = 0; i < `POINT_COUNT; i++)
    begin : g_classifier
        blink_period_classifier u_classifier
        (
            .pixel_clock  (pixel_clock),
            .rst          (rst),
            .clear        (clear),
            .sample_bit   (sample_bits[i]),
            .sample_valid (sample_valid[i]),
            .band         (cfg.bands[i]),
            .counts       (point_counts[i])
        );
    end

    result_reporter u_reporter
    (
        .pixel_clock  (pixel_clock),
        .rst          (rst),
        .stop         (stop),
        .counts       (point_counts),
        .report_valid (report_valid),
        .report       (report),
        .irq          (irq)
    );

endmodule

`default_nettype wire

// ==== hdl/result_reporter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "analyzer_macros.svh"

module result_reporter
(
    input  logic                                                 pixel_clock,
    input  logic                                                 rst,
    input  logic                                                 stop,
    input  analyzer_result_pkg::point_counts_t [`POINT_COUNT-1:0] counts,
    output logic                                                 report_valid,
    output analyzer_result_pkg::report_word_t                    report,
    output logic                                                 irq
);

    logic                           busy;
    logic [`REPORT_INDEX_WIDTH-1:0] step;

    assign report_valid = busy;

    //////////////////////////////////////////////////
    // word select, f0/f1 pairs then unknowns
    //////////////////////////////////////////////////

    always_comb
    begin
        report.index = step;
        case (step)
            4'd1:    report.data = counts[0].f0_count;
            4'd2:    report.data = counts[0].f1_count;
            4'd3:    report.data = counts[1].f0_count;
            4'd4:    report.data = counts[1].f1_count;
            4'd5:    report.data = counts[2].f0_count;
            4'd6:    report.data = counts[2].f1_count;
            4'd7:    report.data = counts[0].unknown_count;
            4'd8:    report.data = counts[1].unknown_count;
            4'd9:    report.data = counts[2].unknown_count;
            default: report.data = '0;
        endcase
    end

    // stop while busy is dropped
    always_ff @(posedge pixel_clock)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            step <= '0;
            irq  <= 1'b0;
        end
        else
        begin
            irq <= 1'b0;
            if (!busy)
            begin
                if (stop)
                begin
                    busy <= 1'b1;
                    step <= `REPORT_INDEX_WIDTH'(1);
                end
            end
            else if (step == `REPORT_INDEX_WIDTH'(`RESULT_COUNT))
            begin
                // last word shown, irq next cycle
                busy <= 1'b0;
                step <= '0;
                irq  <= 1'b1;
            end
            else
            begin
                step <= step + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/blink_period_classifier.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "analyzer_macros.svh"

module blink_period_classifier
(
    input  logic                               pixel_clock,
    input  logic                               rst,
    input  logic                               clear,
    input  logic                               sample_bit,
    input  logic                               sample_valid,
    input  analyzer_cfg_pkg::band_cfg_t        band,
    output analyzer_result_pkg::point_counts_t counts
);

    logic                     previous_bit;
    logic                     armed;
    logic [`PERIOD_WIDTH-1:0] line_count;
    logic                     rising_edge;
    logic                     f0_match;
    logic                     f1_match;

    function automatic logic in_band
    (
        input logic [`PERIOD_WIDTH-1:0] period,
        input logic [`PERIOD_WIDTH-1:0] center,
        input logic [`PERIOD_WIDTH-1:0] deviation
    );
        logic [`PERIOD_WIDTH-1:0] distance;
        distance = (period >= center) ? (period - center) : (center - period);
        return (distance <= deviation);
    endfunction

    assign rising_edge = sample_valid && sample_bit && !previous_bit;

    // line_count holds the lines since the last rising edge
    assign f0_match = in_band(line_count, band.f0_period, band.deviation);
    assign f1_match = in_band(line_count, band.f1_period, band.deviation);

    //////////////////////////////////////////////////
    // period measurement and class counters
    //////////////////////////////////////////////////

    always_ff @(posedge pixel_clock)
    begin
        if (rst)
        begin
            previous_bit <= 1'b0;
            armed        <= 1'b0;
            line_count   <= '0;
            counts       <= '0;
        end
        else
        begin
            if (sample_valid)
                previous_bit <= sample_bit;

            if (clear)
            begin
                armed      <= 1'b0;
                line_count <= '0;
                counts     <= '0;
            end
            else if (rising_edge)
            begin
                // first edge only starts the measurement
                armed      <= 1'b1;
                line_count <= `PERIOD_WIDTH'(1);
                if (armed)
                begin
                    if (f0_match)
                        counts.f0_count <= counts.f0_count + 1'b1;
                    else if (f1_match)
                        counts.f1_count <= counts.f1_count + 1'b1;
                    else
                        counts.unknown_count <= counts.unknown_count + 1'b1;
                end
            end
            else if (sample_valid && (line_count != '1))
            begin
                // saturate, a very long period is simply unknown
                line_count <= line_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/line_scanner.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "analyzer_macros.svh"

module line_scanner
(
    input  logic                                              pixel_clock,
    input  logic                                              rst,
    input  logic                                              start,
    input  logic                                              stop,
    input  logic [`PIXEL_WIDTH-1:0]                           data,
    input  logic [`PIXEL_WIDTH-1:0]                           threshold,
    input  analyzer_cfg_pkg::point_window_t [`POINT_COUNT-1:0] windows,
    output logic [`POINT_COUNT-1:0]                           sample_bits,
    output logic [`POINT_COUNT-1:0]                           sample_valid
);

    logic                         running;
    logic [`LINE_INDEX_WIDTH-1:0] position;
    logic                         line_end;

    assign line_end = (position == `LINE_INDEX_WIDTH'(`LINE_PIXELS - 1));

    // position held at 0 while idle, restarts on start
    always_ff @(posedge pixel_clock)
    begin
        if (rst)
        begin
            running  <= 1'b0;
            position <= '0;
        end
        else
        begin
            if (start)
                running <= 1'b1;
            else if (stop)
                running <= 1'b0;

            if (start || !running || line_end)
                position <= '0;
            else
                position <= position + 1'b1;
        end
    end

    for (genvar i = 0; i < `POINT_COUNT; i++)
    begin : g_sampler
        point_window_sampler u_sampler
        (
            .pixel_clock  (pixel_clock),
            .rst          (rst),
            .running      (running),
            .position     (position),
            .data         (data),
            .threshold    (threshold),
            .window       (windows[i]),
            .sample_bit   (sample_bits[i]),
            .sample_valid (sample_valid[i])
        );
    end

endmodule

`default_nettype wire

// ==== hdl/point_window_sampler.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "analyzer_macros.svh"

module point_window_sampler
(
    input  logic                              pixel_clock,
    input  logic                              rst,
    input  logic                              running,
    input  logic [`LINE_INDEX_WIDTH-1:0]      position,
    input  logic [`PIXEL_WIDTH-1:0]           data,
    input  logic [`PIXEL_WIDTH-1:0]           threshold,
    input  analyzer_cfg_pkg::point_window_t   window,
    output logic                              sample_bit,
    output logic                              sample_valid
);

    logic [`PIXEL_WIDTH-1:0] min_value;
    logic [`PIXEL_WIDTH-1:0] max_value;
    logic [`PIXEL_WIDTH-1:0] line_min;
    logic [`PIXEL_WIDTH-1:0] line_max;
    logic [`PIXEL_WIDTH-1:0] midpoint;
    logic                    in_window;
    logic                    at_stop;

    assign in_window = (position >= window.start_index) && (position < window.stop_index);
    assign at_stop   = running && (position == window.stop_index);

    // empty range at the start of each line
    assign line_min = (position == '0) ? '1 : min_value;
    assign line_max = (position == '0) ? '0 : max_value;

    // rounded down, no overflow since max >= min
    assign midpoint = min_value + ((max_value - min_value) >> 1);

    //////////////////////////////////////////////////
    // window range tracking
    //////////////////////////////////////////////////

    always_ff @(posedge pixel_clock)
    begin
        if (in_window)
        begin
            min_value <= (data < line_min) ? data : line_min;
            max_value <= (data > line_max) ? data : line_max;
        end
        else
        begin
            min_value <= line_min;
            max_value <= line_max;
        end
    end

    //////////////////////////////////////////////////
    // light/dark decision
    //////////////////////////////////////////////////

    always_ff @(posedge pixel_clock)
    begin
        if (rst)
        begin
            sample_bit   <= 1'b0;
            sample_valid <= 1'b0;
        end
        else
        begin
            sample_valid <= at_stop;
            // equal to threshold still counts as dark
            if (at_stop)
                sample_bit <= (midpoint > threshold);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/analyzer_result_pkg.sv ====
`default_nettype none

`include "analyzer_macros.svh"

package analyzer_result_pkg;

    typedef struct packed
    {
        logic [`COUNT_WIDTH-1:0] f0_count;
        logic [`COUNT_WIDTH-1:0] f1_count;
        logic [`COUNT_WIDTH-1:0] unknown_count;
    } point_counts_t;

    // index runs 1 to 9, 0 when idle
    typedef struct packed
    {
        logic [`REPORT_INDEX_WIDTH-1:0] index;
        logic [`COUNT_WIDTH-1:0]        data;
    } report_word_t;

endpackage

`default_nettype wire

// ==== hdl/analyzer_cfg_pkg.sv ====
`default_nettype none

`include "analyzer_macros.svh"

package analyzer_cfg_pkg;

    // start inclusive, stop exclusive
    typedef struct packed
    {
        logic [`LINE_INDEX_WIDTH-1:0] start_index;
        logic [`LINE_INDEX_WIDTH-1:0] stop_index;
    } point_window_t;

    // periods in lines, f0 wins over f1
    typedef struct packed
    {
        logic [`PERIOD_WIDTH-1:0] f0_period;
        logic [`PERIOD_WIDTH-1:0] f1_period;
        logic [`PERIOD_WIDTH-1:0] deviation;
    } band_cfg_t;

    typedef struct packed
    {
        logic [`PIXEL_WIDTH-1:0]            threshold;
        point_window_t [`POINT_COUNT-1:0]   windows;
        band_cfg_t [`POINT_COUNT-1:0]       bands;
    } analyzer_cfg_t;

endpackage

`default_nettype wire

// ==== hdl/analyzer_macros.svh ====
`ifndef ANALYZER_MACROS_SVH
`define ANALYZER_MACROS_SVH

// pixel stream
`define PIXEL_WIDTH 8
`define LINE_INDEX_WIDTH 11

// line layout, dark part comes first
`define DARK_PIXELS 16
`define COLOR_PIXELS 1024
`define LINE_PIXELS (`DARK_PIXELS + `COLOR_PIXELS)

`define POINT_COUNT 3

// counters and report
`define COUNT_WIDTH 32
`define PERIOD_WIDTH 16
`define RESULT_COUNT 9
`define REPORT_INDEX_WIDTH 4

`endif
